// File: design/video_pkg.sv
// Fixed raster geometry and bus widths, with no runtime configuration and a single 16-bit CPU data width
package video_pkg;

    // Raster geometry in pixels and lines
    localparam int H_TOTAL  = 48;
    localparam int H_ACTIVE = 32;
    localparam int V_TOTAL  = 224;
    localparam int V_ACTIVE = 200;
    localparam int HS_START = 36;
    localparam int HS_END   = 40;
    localparam int VS_LINE  = 210;

    // Lines that pull line_intn low
    localparam int INT_LINE_A = 64;
    localparam int INT_LINE_B = 128;
    localparam int INT_LINE_C = 192;

    // Counter and data widths
    localparam int H_W    = 6;
    localparam int V_W    = 8;
    localparam int DATA_W = 16;
    localparam int ADDR_W = 8;
    localparam int CIDX_W = 6;
    localparam int RIDX_W = 4;
    localparam int COL_W  = 5;

    // Memory depths and their address widths
    localparam int TILE_WORDS = 128;
    localparam int ROAD_WORDS = 256;
    localparam int PAL_WORDS  = 64;
    localparam int TILE_AW    = $clog2(TILE_WORDS);
    localparam int ROAD_AW    = $clog2(ROAD_WORDS);
    localparam int PAL_AW     = $clog2(PAL_WORDS);

    typedef enum logic [1:0] {
        LAYER_BG,
        LAYER_ROAD,
        LAYER_CHAR
    } layer_e;

    // Beam position plus blanking flags, 16 bits
    typedef struct packed {
        logic [H_W-1:0] h;
        logic [V_W-1:0] v;
        logic           hb;
        logic           vb;
    } beam_t;

    // Stage 1 result handed to the mixer
    typedef struct packed {
        beam_t             beam;
        logic [CIDX_W-1:0] char_idx;
        logic [RIDX_W-1:0] road_idx;
    } layer_px_t;

    // CPU write bundle, byte strobes active low
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [1:0]        dswn;
    } cpu_wr_t;

    // Upper byte on dswn[1], lower byte on dswn[0]
    function automatic logic [DATA_W-1:0] byte_merge(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [1:0]        dswn
    );
        logic [DATA_W-1:0] merged;
        merged = old_word;
        if (!dswn[1]) begin
            merged[15:8] = new_word[15:8];
        end
        if (!dswn[0]) begin
            merged[7:0] = new_word[7:0];
        end
        return merged;
    endfunction

endpackage

// File: design/video_timing.sv
// Counters step only on pxl_cen, sync and blanking decode combinationally, line_intn updates every clk
`timescale 1ns/1ns

module video_timing import video_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  pxl_cen,
    output beam_t beam,
    output logic  hs,
    output logic  vs,
    output logic  line_intn
);

    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic           h_last;
    logic           v_last;

    assign h_last = (h_cnt == H_W'(H_TOTAL - 1));
    assign v_last = (v_cnt == V_W'(V_TOTAL - 1));

    // Horizontal counter wraps and steps the line counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pxl_cen) begin
            if (h_last) begin
                h_cnt <= '0;
                if (v_last) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        beam.h  = h_cnt;
        beam.v  = v_cnt;
        beam.hb = (h_cnt >= H_W'(H_ACTIVE));
        beam.vb = (v_cnt >= V_W'(V_ACTIVE));
    end

    assign hs = (h_cnt >= H_W'(HS_START)) && (h_cnt < H_W'(HS_END));
    assign vs = (v_cnt == V_W'(VS_LINE));

    // Low for the whole interrupt line, one clk behind vdump
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_intn <= 1'b1;
        end else begin
            line_intn <= !(v_cnt == V_W'(INT_LINE_A) ||
                           v_cnt == V_W'(INT_LINE_B) ||
                           v_cnt == V_W'(INT_LINE_C));
        end
    end

endmodule

// File: design/char_layer.sv
// Tile pixels come straight from the tile word, no ROM fetch, no scroll and no flip
`timescale 1ns/1ns

module char_layer import video_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  beam_t             beam_in,
    input  cpu_wr_t           cpu,
    input  logic              char_cs,
    output logic [DATA_W-1:0] char_dout,
    output beam_t             beam_out,
    output logic [CIDX_W-1:0] char_idx
);

    logic [DATA_W-1:0]  tile_ram [TILE_WORDS];
    logic               cpu_we;
    logic [TILE_AW-1:0] cpu_a;
    logic [TILE_AW-1:0] tile_addr;
    logic [DATA_W-1:0]  tile_word;
    logic [3:0]         code;
    logic [1:0]         group;
    logic [CIDX_W-1:0]  idx_next;

    assign cpu_a  = cpu.addr[TILE_AW-1:0];
    assign cpu_we = char_cs && (cpu.dswn != 2'b11);

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            tile_ram[cpu_a] <= byte_merge(tile_ram[cpu_a], cpu.data, cpu.dswn);
        end
    end

    assign char_dout = tile_ram[cpu_a];

    // Map is 4 tiles wide, row = v/8 and column = h/8
    // h[5] only matters in blanking, so it drops out
    assign tile_addr = {beam_in.v[7:3], beam_in.h[4:3]};
    assign tile_word = tile_ram[tile_addr];
    assign code      = tile_word[3:0];
    assign group     = tile_word[5:4];

    // Code 0 is transparent
    always_comb begin
        if (code == 4'd0) begin
            idx_next = '0;
        end else begin
            idx_next = {group, code};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beam_out <= '0;
            char_idx <= '0;
        end else if (pxl_cen) begin
            beam_out <= beam_in;
            char_idx <= idx_next;
        end
    end

endmodule

// File: design/road_layer.sv
// One road span per line with a flat color, no road ROM and no per-pixel shading
`timescale 1ns/1ns

module road_layer import video_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  beam_t             beam_in,
    input  cpu_wr_t           sub,
    input  logic              road_cs,
    input  logic              sub_rnw,
    output logic [DATA_W-1:0] road_dout,
    output logic [RIDX_W-1:0] road_idx
);

    logic [DATA_W-1:0]  road_ram [ROAD_WORDS];
    logic               sub_we;
    logic [ROAD_AW-1:0] sub_a;
    logic [DATA_W-1:0]  line_entry;
    logic [H_W-1:0]     left_edge;
    logic [H_W-1:0]     right_edge;
    logic [RIDX_W-1:0]  road_color;
    logic               in_span;

    assign sub_a  = sub.addr[ROAD_AW-1:0];
    assign sub_we = road_cs && !sub_rnw;

    always_ff @(posedge clk) begin
        if (sub_we) begin
            road_ram[sub_a] <= byte_merge(road_ram[sub_a], sub.data, sub.dswn);
        end
    end

    assign road_dout = road_ram[sub_a];

    // Entry for the current line
    assign line_entry = road_ram[beam_in.v];
    assign left_edge  = line_entry[5:0];
    assign right_edge = line_entry[11:6];
    assign road_color = line_entry[15:12];

    // Right edge is exclusive
    assign in_span = (beam_in.h >= left_edge) && (beam_in.h < right_edge);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            road_idx <= '0;
        end else if (pxl_cen) begin
            road_idx <= in_span ? road_color : '0;
        end
    end

endmodule

// File: design/color_mixer.sv
// Fixed priority char over road over background, palette is 5:5:5 RGB with red in the low bits
`timescale 1ns/1ns

module color_mixer import video_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  layer_px_t         px,
    input  cpu_wr_t           cpu,
    input  logic              pal_cs,
    output logic [DATA_W-1:0] pal_dout,
    output logic [COL_W-1:0]  red,
    output logic [COL_W-1:0]  green,
    output logic [COL_W-1:0]  blue,
    output logic              lhbl,
    output logic              lvbl
);

    logic [DATA_W-1:0] pal_ram [PAL_WORDS];
    logic              cpu_we;
    logic [PAL_AW-1:0] cpu_a;
    layer_e            layer_sel;
    logic [PAL_AW-1:0] pal_addr;
    logic [DATA_W-1:0] pal_word;
    logic              blank;

    assign cpu_a  = cpu.addr[PAL_AW-1:0];
    assign cpu_we = pal_cs && (cpu.dswn != 2'b11);

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            pal_ram[cpu_a] <= byte_merge(pal_ram[cpu_a], cpu.data, cpu.dswn);
        end
    end

    assign pal_dout = pal_ram[cpu_a];

    // Priority pick
    always_comb begin
        if (px.char_idx != '0) begin
            layer_sel = LAYER_CHAR;
        end else if (px.road_idx != '0) begin
            layer_sel = LAYER_ROAD;
        end else begin
            layer_sel = LAYER_BG;
        end
    end

    always_comb begin
        case (layer_sel)
            LAYER_CHAR: pal_addr = px.char_idx;
            LAYER_ROAD: pal_addr = PAL_AW'(px.road_idx);
            default:    pal_addr = '0;
        endcase
    end

    assign pal_word = pal_ram[pal_addr];
    assign blank    = px.beam.hb || px.beam.vb;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
            lhbl  <= 1'b0;
            lvbl  <= 1'b0;
        end else if (pxl_cen) begin
            // Black outside the active area
            red   <= blank ? '0 : pal_word[4:0];
            green <= blank ? '0 : pal_word[9:5];
            blue  <= blank ? '0 : pal_word[14:10];
            lhbl  <= !px.beam.hb;
            lvbl  <= !px.beam.vb;
        end
    end

endmodule

// File: design/video_top.sv
// Three-stage pixel pipeline on pxl_cen, CPU RAM reads are combinational and writes land next clk
`timescale 1ns/1ns

module video_top import video_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,

    // Main CPU
    input  logic              char_cs,
    input  logic              pal_cs,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic [DATA_W-1:0] cpu_dout,
    input  logic [1:0]        main_dswn,

    // Sub CPU
    input  logic              road_cs,
    input  logic              sub_rnw,
    input  logic [ADDR_W-1:0] sub_addr,
    input  logic [DATA_W-1:0] sub_dout,
    input  logic [1:0]        sub_dsn,

    output logic [DATA_W-1:0] char_dout,
    output logic [DATA_W-1:0] pal_dout,
    output logic [DATA_W-1:0] road_dout,

    // Video
    output logic              hs,
    output logic              vs,
    output logic              lhbl,
    output logic              lvbl,
    output logic              line_intn,
    output logic [H_W-1:0]    hdump,
    output logic [V_W-1:0]    vdump,
    output logic [COL_W-1:0]  red,
    output logic [COL_W-1:0]  green,
    output logic [COL_W-1:0]  blue
);

    cpu_wr_t           main_wr;
    cpu_wr_t           sub_wr;
    beam_t             beam_s0;
    beam_t             beam_s1;
    logic [CIDX_W-1:0] char_idx;
    logic [RIDX_W-1:0] road_idx;
    layer_px_t         layer_px;

    assign main_wr = '{addr: cpu_addr, data: cpu_dout, dswn: main_dswn};
    assign sub_wr  = '{addr: sub_addr, data: sub_dout, dswn: sub_dsn};

    assign hdump = beam_s0.h;
    assign vdump = beam_s0.v;

    video_timing u_timing (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .beam      ( beam_s0   ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .line_intn ( line_intn )
    );

    char_layer u_char (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .beam_in   ( beam_s0   ),
        .cpu       ( main_wr   ),
        .char_cs   ( char_cs   ),
        .char_dout ( char_dout ),
        .beam_out  ( beam_s1   ),
        .char_idx  ( char_idx  )
    );

    road_layer u_road (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .beam_in   ( beam_s0   ),
        .sub       ( sub_wr    ),
        .road_cs   ( road_cs   ),
        .sub_rnw   ( sub_rnw   ),
        .road_dout ( road_dout ),
        .road_idx  ( road_idx  )
    );

    // Both layer results meet the forwarded beam here
    assign layer_px = '{beam: beam_s1, char_idx: char_idx, road_idx: road_idx};

    color_mixer u_mixer (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .px       ( layer_px ),
        .cpu      ( main_wr  ),
        .pal_cs   ( pal_cs   ),
        .pal_dout ( pal_dout ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     )
    );

endmodule

// File: tests/video_sva.sv
// Bound into video_top, fail_count holds the number of assertion failures for the testbench
`timescale 1ns/1ns

module video_sva import video_pkg::*; (
    input logic             clk,
    input logic             rst,
    input logic [H_W-1:0]   hdump,
    input logic [V_W-1:0]   vdump,
    input logic             hs,
    input logic             line_intn,
    input logic             lhbl,
    input logic             lvbl,
    input logic [COL_W-1:0] red,
    input logic [COL_W-1:0] green,
    input logic [COL_W-1:0] blue
);

    int   fail_count = 0;
    logic int_line;

    assign int_line = (vdump == V_W'(INT_LINE_A)) || (vdump == V_W'(INT_LINE_B)) ||
                      (vdump == V_W'(INT_LINE_C));

    // line_intn follows the interrupt lines one clk late, in both directions
    a_intn_low: assert property (@(posedge clk) disable iff (rst) int_line |=> !line_intn)
        else begin $error("line_intn stayed high after an interrupt line"); fail_count++; end
    a_intn_high: assert property (@(posedge clk) disable iff (rst) !int_line |=> line_intn)
        else begin $error("line_intn low outside an interrupt line"); fail_count++; end

    a_blank_black: assert property (@(posedge clk) disable iff (rst)
        (!lhbl || !lvbl) |-> (red == '0 && green == '0 && blue == '0))
        else begin $error("RGB not black during blanking"); fail_count++; end

    a_h_range: assert property (@(posedge clk) disable iff (rst) hdump < H_TOTAL)
        else begin $error("hdump beyond the line length"); fail_count++; end

    a_hs_window: assert property (@(posedge clk) disable iff (rst)
        hs |-> (hdump >= HS_START && hdump < HS_END))
        else begin $error("HS active outside its window"); fail_count++; end

endmodule

bind video_top video_sva u_sva (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .hdump     ( hdump     ),
    .vdump     ( vdump     ),
    .hs        ( hs        ),
    .line_intn ( line_intn ),
    .lhbl      ( lhbl      ),
    .lvbl      ( lvbl      ),
    .red       ( red       ),
    .green     ( green     ),
    .blue      ( blue      )
);

// File: tests/tb_video.sv
// CPU traffic stops while a frame is compared, RAMs are fully written before any pixel check
`timescale 1ns/1ns

module tb_video import video_pkg::*; ();

    logic              clk;
    logic              rst;
    logic              pxl_cen;
    logic              char_cs;
    logic              pal_cs;
    logic [ADDR_W-1:0] cpu_addr;
    logic [DATA_W-1:0] cpu_dout;
    logic [1:0]        main_dswn;
    logic              road_cs;
    logic              sub_rnw;
    logic [ADDR_W-1:0] sub_addr;
    logic [DATA_W-1:0] sub_dout;
    logic [1:0]        sub_dsn;
    logic [DATA_W-1:0] char_dout;
    logic [DATA_W-1:0] pal_dout;
    logic [DATA_W-1:0] road_dout;
    logic              hs;
    logic              vs;
    logic              lhbl;
    logic              lvbl;
    logic              line_intn;
    logic [H_W-1:0]    hdump;
    logic [V_W-1:0]    vdump;
    logic [COL_W-1:0]  red;
    logic [COL_W-1:0]  green;
    logic [COL_W-1:0]  blue;

    // Model copies of the three RAMs
    logic [15:0] tile_m [TILE_WORDS];
    logic [15:0] road_m [ROAD_WORDS];
    logic [15:0] pal_m  [PAL_WORDS];

    int          errors;
    int          checks;
    int          frame_count;
    int          hits [4];
    int          prev_h;
    int          prev_v;
    int          next_h;
    int          next_v;
    int          win;
    logic        track_valid;
    logic        check_on;
    logic [1:0]  exp_sync;
    logic [31:0] rng_state;
    logic [16:0] exp_px;
    logic [30:0] exp_entry;
    logic [30:0] exp_q [$];
    string       test_name;

    video_top dut (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .char_cs(char_cs), .pal_cs(pal_cs), .cpu_addr(cpu_addr),
        .cpu_dout(cpu_dout), .main_dswn(main_dswn),
        .road_cs(road_cs), .sub_rnw(sub_rnw), .sub_addr(sub_addr),
        .sub_dout(sub_dout), .sub_dsn(sub_dsn),
        .char_dout(char_dout), .pal_dout(pal_dout), .road_dout(road_dout),
        .hs(hs), .vs(vs), .lhbl(lhbl), .lvbl(lvbl), .line_intn(line_intn),
        .hdump(hdump), .vdump(vdump), .red(red), .green(green), .blue(blue)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Pixel enable on every other clk
    always @(posedge clk) begin
        pxl_cen <= rst ? 1'b0 : !pxl_cen;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [15:0] merge_bytes(input logic [15:0] old_w, input logic [15:0] new_w,
                                                 input logic [1:0] strobes);
        return {strobes[1] ? old_w[15:8] : new_w[15:8], strobes[0] ? old_w[7:0] : new_w[7:0]};
    endfunction

    // {lhbl, lvbl, blue, green, red} for one beam position, layer 3 means blanked
    function automatic logic [16:0] expected_pixel(input int h, input int v, output int layer);
        logic [15:0] tile;
        logic [15:0] entry;
        int          idx;
        tile  = tile_m[(v / 8) * 4 + h / 8];
        entry = road_m[v];
        idx   = 0;
        layer = 0;
        if (tile[3:0] != 4'd0) begin
            layer = 2;
            idx   = tile[5:0];
        end else if (h >= entry[5:0] && h < entry[11:6] && entry[15:12] != 4'd0) begin
            layer = 1;
            idx   = entry[15:12];
        end
        if (h >= H_ACTIVE || v >= V_ACTIVE) begin
            layer = 3;
            return {h < H_ACTIVE, v < V_ACTIVE, 15'd0};
        end
        return {2'b11, pal_m[idx][14:0]};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Mismatch %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic main_write(input logic to_pal, input int a, input logic [15:0] d,
                              input logic [1:0] s);
        @(posedge clk);
        char_cs   <= !to_pal;
        pal_cs    <= to_pal;
        cpu_addr  <= 8'(a);
        cpu_dout  <= d;
        main_dswn <= s;
        @(posedge clk);
        char_cs   <= 1'b0;
        pal_cs    <= 1'b0;
        main_dswn <= 2'b11;
        if (to_pal) begin
            pal_m[a % PAL_WORDS] = merge_bytes(pal_m[a % PAL_WORDS], d, s);
        end else begin
            tile_m[a % TILE_WORDS] = merge_bytes(tile_m[a % TILE_WORDS], d, s);
        end
    endtask

    task automatic sub_write(input int a, input logic [15:0] d, input logic [1:0] s);
        @(posedge clk);
        road_cs  <= 1'b1;
        sub_rnw  <= 1'b0;
        sub_addr <= 8'(a);
        sub_dout <= d;
        sub_dsn  <= s;
        @(posedge clk);
        road_cs  <= 1'b0;
        sub_rnw  <= 1'b1;
        road_m[a] = merge_bytes(road_m[a], d, s);
    endtask

    // Half the tiles transparent, road spans start inside the active width
    task automatic fill_memories();
        logic [31:0] r;
        logic [15:0] d;
        for (int i = 0; i < ROAD_WORDS; i++) begin
            r = next_random();
            d = r[31:16];
            if (i < TILE_WORDS) begin
                main_write(1'b0, i, r[0] ? {d[15:4], 4'd0} : d, 2'b00);
            end
            if (i < PAL_WORDS) begin
                main_write(1'b1, i, d ^ 16'(r[15:0]), 2'b00);
            end
            d[5:0]  = 6'(r[4:0]);
            d[11:6] = 6'(r[4:0]) + 6'(r[9:5]);
            sub_write(i, d, 2'b00);
        end
    endtask

    task automatic random_writes(input int count);
        logic [31:0] r;
        repeat (count) begin
            r = next_random();
            case (r[1:0])
                2'd0:    main_write(1'b0, r[9:2], r[31:16], r[11:10]);
                2'd1:    main_write(1'b1, r[9:2], r[31:16], r[11:10]);
                default: sub_write(r[9:2], r[31:16], r[11:10]);
            endcase
        end
    endtask

    task automatic read_back_all();
        for (int i = 0; i < ROAD_WORDS; i++) begin
            @(posedge clk);
            cpu_addr <= 8'(i);
            sub_addr <= 8'(i);
            @(posedge clk);
            check_value($sformatf("road[%0d]", i), road_m[i], road_dout);
            if (i < TILE_WORDS) check_value($sformatf("tile[%0d]", i), tile_m[i], char_dout);
            if (i < PAL_WORDS) check_value($sformatf("pal[%0d]", i), pal_m[i], pal_dout);
        end
    endtask

    task automatic wait_frames(input int count);
        int target;
        int cycles;
        target = frame_count + count;
        cycles = 0;
        while (frame_count < target && cycles < count * H_TOTAL * V_TOTAL * 2 + 200) begin
            @(posedge clk);
            cycles++;
        end
        if (frame_count < target) begin
            errors++;
            $display("Timed out waiting for the raster to finish a frame");
        end
    endtask

    // Raster count and sync tracking, pixel comparison two pxl_cen steps late
    always @(posedge clk) begin
        if (!rst && pxl_cen) begin
            if (track_valid) begin
                next_h = (prev_h == H_TOTAL - 1) ? 0 : prev_h + 1;
                next_v = prev_v;
                if (prev_h == H_TOTAL - 1) next_v = (prev_v == V_TOTAL - 1) ? 0 : prev_v + 1;
                checks++;
                assert (hdump == next_h && vdump == next_v) else begin
                    errors++;
                    $display("Mismatch raster count: expected %0d/%0d, actual %0d/%0d",
                             next_h, next_v, hdump, vdump);
                end
            end
            // HS inside its window, VS on one line only
            exp_sync = {hdump >= HS_START && hdump < HS_END, vdump == VS_LINE};
            checks++;
            assert ({hs, vs} === exp_sync) else begin
                errors++;
                $display("Mismatch sync at %0d/%0d: expected %b, actual %b",
                         hdump, vdump, exp_sync, {hs, vs});
            end
            if (hdump == H_TOTAL - 1 && vdump == V_TOTAL - 1) frame_count++;
            prev_h      = hdump;
            prev_v      = vdump;
            track_valid = 1'b1;
            if (check_on) begin
                exp_px = expected_pixel(hdump, vdump, win);
                hits[win]++;
                exp_q.push_back({hdump, vdump, exp_px});
                if (exp_q.size() > 2) begin
                    exp_entry = exp_q.pop_front();
                    checks++;
                    assert ({lhbl, lvbl, blue, green, red} === exp_entry[16:0]) else begin
                        errors++;
                        $display("Mismatch %s at %0d/%0d: expected %h, actual %h", test_name,
                                 exp_entry[30:25], exp_entry[24:17], exp_entry[16:0],
                                 {lhbl, lvbl, blue, green, red});
                    end
                end
            end else begin
                exp_q.delete();
            end
        end
    end

    initial begin
        rst         = 1'b1;
        pxl_cen     = 1'b0;
        char_cs     = 1'b0;
        pal_cs      = 1'b0;
        cpu_addr    = '0;
        cpu_dout    = '0;
        main_dswn   = 2'b11;
        road_cs     = 1'b0;
        sub_rnw     = 1'b1;
        sub_addr    = '0;
        sub_dout    = '0;
        sub_dsn     = 2'b11;
        rng_state   = 32'h8b94;
        errors      = 0;
        checks      = 0;
        frame_count = 0;
        hits        = '{0, 0, 0, 0};
        track_valid = 1'b0;
        check_on    = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        test_name = "reset";
        check_value("line_intn", 1, line_intn);
        check_value("rgb", 0, {blue, green, red});
        check_value("blank flags", 0, {lhbl, lvbl});
        check_value("counters", 0, {hdump, vdump});

        test_name = "readback";
        fill_memories();
        random_writes(90);
        read_back_all();

        // Nonzero background so blanking has something to hide
        main_write(1'b1, 0, 16'h2a55, 2'b00);
        wait_frames(1);

        test_name = "frame pixels";
        check_on <= 1'b1;
        wait_frames(1);
        check_on <= 1'b0;
        checks++;
        assert (hits[0] > 0 && hits[1] > 0 && hits[2] > 0 && hits[3] > 0) else begin
            errors++;
            $display("The checked frame did not show every layer: bg %0d, road %0d, char %0d",
                     hits[0], hits[1], hits[2]);
        end

        $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 dut.u_sva.fail_count);
        if (errors == 0 && dut.u_sva.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: flist.f
design/video_pkg.sv
design/video_timing.sv
design/char_layer.sv
design/road_layer.sv
design/color_mixer.sv
design/video_top.sv
tests/video_sva.sv
tests/tb_video.sv
